//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - common/bpu_pkg.sv
      - bpu/branch_target_table.sv
      - bpu/return_stack.sv
      - bpu/slot_select.sv
      - logic/fetch_pc_gen.sv
      - logic/fetch_frontend.sv
  - target: test
    files:
      - verification/fetch_frontend_tb.sv

//--- bpu/branch_target_table.sv
// direct-mapped table, table_entries must be a power of two >= 4; training shows one cycle later
module branch_target_table #(
  parameter int unsigned table_entries = 64
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic [31:0]                                     pc,
  input  bpu_pkg::resolve_t                               resolve0,
  input  bpu_pkg::resolve_t                               resolve1,
  output bpu_pkg::slot_pred_t [bpu_pkg::group_slots-1:0]  slots
);

  localparam int unsigned idx_w = $clog2(table_entries);
  // word address bits above the index
  localparam int unsigned tag_w = 30 - idx_w;

  typedef struct packed {
    logic [tag_w-1:0]      tag;
    bpu_pkg::branch_kind_e kind;
    logic [31:0]           target;
    logic [1:0]            ctr;
  } payload_t;

  typedef struct packed {
    logic     valid;
    payload_t data;
  } entry_t;

  logic [table_entries-1:0] valid_q;
  payload_t                 mem_q [table_entries];

  bpu_pkg::resolve_t res [2];
  logic [idx_w-1:0]  widx [2];
  logic              wr [2];
  entry_t            wdata [2];

  logic [idx_w-1:0] base_idx;
  logic [tag_w-1:0] rtag;

  // first entry of the group, then the tag above the index
  assign base_idx = pc[idx_w+1:2] & ~idx_w'(bpu_pkg::group_slots - 1);
  assign rtag     = pc[31:idx_w+2];

  always_comb begin
    logic [idx_w-1:0] ridx;
    ridx = base_idx;
    for (int k = 0; k < bpu_pkg::group_slots; k++) begin
      ridx = base_idx + idx_w'(k);
      slots[k].hit    = valid_q[ridx] && (mem_q[ridx].tag == rtag) && (mem_q[ridx].ctr >= 2'd2);
      slots[k].kind   = mem_q[ridx].kind;
      slots[k].target = mem_q[ridx].target;
    end
  end

  assign res[0] = resolve0;
  assign res[1] = resolve1;

  // port 1 trains on top of port 0's result when both hit one index
  always_comb begin
    entry_t           cur;
    logic             match;
    logic [tag_w-1:0] wtag;
    for (int p = 0; p < 2; p++) begin
      widx[p]    = res[p].pc[idx_w+1:2];
      wtag       = res[p].pc[31:idx_w+2];
      cur.valid  = valid_q[widx[p]];
      cur.data   = mem_q[widx[p]];
      if (p == 1 && wr[0] && widx[0] == widx[1]) begin
        cur = wdata[0];
      end
      match    = cur.valid && (cur.data.tag == wtag);
      wdata[p] = cur;
      wr[p]    = 1'b0;
      if (res[p].valid && res[p].is_branch) begin
        if (res[p].taken) begin
          wr[p]              = 1'b1;
          wdata[p].valid     = 1'b1;
          wdata[p].data.tag  = wtag;
          wdata[p].data.kind = res[p].kind;
          wdata[p].data.target = res[p].target;
          if (!match) begin
            // fresh allocation starts weakly taken
            wdata[p].data.ctr = 2'd2;
          end else if (cur.data.ctr != 2'd3) begin
            wdata[p].data.ctr = cur.data.ctr + 2'd1;
          end
        end else if (match) begin
          wr[p] = 1'b1;
          if (cur.data.ctr != 2'd0) begin
            wdata[p].data.ctr = cur.data.ctr - 2'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (wr[p]) begin
          valid_q[widx[p]] <= wdata[p].valid;
        end
      end
    end
  end

  // later port wins on a shared index
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (wr[p]) begin
        mem_q[widx[p]] <= wdata[p].data;
      end
    end
  end

endmodule

//--- bpu/return_stack.sv
// wrapping stack, ras_depth a power of two >= 2; no overflow guard, top is undefined while empty
module return_stack #(
  parameter int unsigned ras_depth = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  bpu_pkg::resolve_t resolve0,
  input  bpu_pkg::resolve_t resolve1,
  input  logic              pop,
  input  logic              issue,
  output logic [31:0]       top
);

  localparam int unsigned ptr_w = $clog2(ras_depth);

  logic [31:0]      mem_q [ras_depth];
  // next free slot
  logic [ptr_w-1:0] ptr_q;
  logic [ptr_w-1:0] ptr_popped;
  logic             push0;
  logic             push1;

  // only resolved taken calls push
  assign push0 = resolve0.valid && resolve0.is_branch && resolve0.taken &&
                 (resolve0.kind == bpu_pkg::br_call);
  assign push1 = resolve1.valid && resolve1.is_branch && resolve1.taken &&
                 (resolve1.kind == bpu_pkg::br_call);

  // pop applies before the pushes of the same cycle
  assign ptr_popped = ptr_q - ptr_w'(pop && issue);

  assign top = mem_q[ptr_q - ptr_w'(1)];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_popped + ptr_w'(push0) + ptr_w'(push1);
    end
  end

  always_ff @(posedge clk) begin
    if (push0) begin
      mem_q[ptr_popped] <= resolve0.pc + 32'(bpu_pkg::slot_bytes);
    end
    if (push1) begin
      mem_q[ptr_popped + ptr_w'(push0)] <= resolve1.pc + 32'(bpu_pkg::slot_bytes);
    end
  end

endmodule

//--- bpu/slot_select.sv
// purely combinational; pred.valid is always low here and is set by the issue stage
module slot_select (
  input  logic [31:0]                                    pc,
  input  bpu_pkg::slot_pred_t [bpu_pkg::group_slots-1:0] slots,
  input  logic [31:0]                                    ras_top,
  output bpu_pkg::fetch_group_t                          pred,
  output logic                                           pop
);

  logic [1:0] offset;
  logic [3:0] eligible;
  logic       found;
  logic [1:0] sel;

  assign offset = pc[3:2];

  // slots before the entry offset never count
  always_comb begin
    for (int k = 0; k < bpu_pkg::group_slots; k++) begin
      eligible[k] = slots[k].hit && (2'(k) >= offset);
    end
  end

  // lowest eligible position wins
  always_comb begin
    found = 1'b0;
    sel   = 2'd0;
    for (int k = 0; k < bpu_pkg::group_slots; k++) begin
      if (eligible[k] && !found) begin
        found = 1'b1;
        sel   = 2'(k);
      end
    end
  end

  always_comb begin
    logic [31:0] seq_pc;
    seq_pc          = {pc[31:4], 4'b0000} + 32'(bpu_pkg::group_bytes);
    pred.valid      = 1'b0;
    pred.pc         = pc;
    pred.taken_slot = 4'b0000;
    pred.next_pc    = seq_pc;
    for (int k = 0; k < bpu_pkg::group_slots; k++) begin
      pred.slot_valid[k] = (2'(k) >= offset) && (!found || 2'(k) <= sel);
    end
    if (found) begin
      pred.taken_slot[sel] = 1'b1;
      // returns take the stack top, everything else the stored target
      if (slots[sel].kind == bpu_pkg::br_ret) begin
        pred.next_pc = ras_top;
      end else begin
        pred.next_pc = slots[sel].target;
      end
    end
  end

  // stack only moves when the group actually issues
  assign pop = found && (slots[sel].kind == bpu_pkg::br_ret);

endmodule

//--- common/bpu_pkg.sv
// shared fetch types; groups are four aligned 32-bit slots, so a group covers 16 bytes
package bpu_pkg;

  // fetch group geometry
  localparam int unsigned group_slots = 4;
  localparam int unsigned slot_bytes  = 4;
  localparam int unsigned group_bytes = group_slots * slot_bytes;

  typedef enum logic [1:0] {
    br_cond = 2'd0,
    br_jump = 2'd1,
    br_call = 2'd2,
    br_ret  = 2'd3
  } branch_kind_e;

  // one resolved instruction from execute
  typedef struct packed {
    logic         valid;
    logic [31:0]  pc;
    logic         is_branch;
    logic         taken;
    logic         mispredict;
    logic [31:0]  target;
    branch_kind_e kind;
    logic [31:0]  redirect_pc;
  } resolve_t;

  // group handed to the consumer
  // taken_slot is one-hot, or zero when the group falls through
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [3:0]  slot_valid;
    logic [3:0]  taken_slot;
    logic [31:0] next_pc;
  } fetch_group_t;

  // per-slot lookup result
  // hit already includes the counter threshold
  typedef struct packed {
    logic         hit;
    branch_kind_e kind;
    logic [31:0]  target;
  } slot_pred_t;

endpackage

//--- filelist.f
common/bpu_pkg.sv
bpu/branch_target_table.sv
bpu/return_stack.sv
bpu/slot_select.sv
logic/fetch_pc_gen.sv
logic/fetch_frontend.sv
verification/fetch_frontend_tb.sv

//--- logic/fetch_frontend.sv
// two-stage prediction front end; no flush of delivered groups, no global history
module fetch_frontend #(
  parameter int unsigned table_entries = 64,
  parameter int unsigned ras_depth     = 8,
  parameter int unsigned credits       = 4,
  parameter logic [31:0] reset_pc      = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  credit_return,
  input  bpu_pkg::resolve_t     resolve0,
  input  bpu_pkg::resolve_t     resolve1,
  output bpu_pkg::fetch_group_t group
);

  logic [31:0]                                    pc;
  logic                                           issue;
  logic                                           pop;
  logic [31:0]                                    ras_top;
  bpu_pkg::slot_pred_t [bpu_pkg::group_slots-1:0] slots;
  bpu_pkg::fetch_group_t                          pred;

  fetch_pc_gen #(
    .credits  (credits),
    .reset_pc (reset_pc)
  ) pc_gen0 (
    .clk           (clk),
    .reset         (reset),
    .credit_return (credit_return),
    .resolve0      (resolve0),
    .resolve1      (resolve1),
    .pred          (pred),
    .pc            (pc),
    .issue         (issue),
    .group         (group)
  );

  branch_target_table #(
    .table_entries (table_entries)
  ) btb0 (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .resolve0 (resolve0),
    .resolve1 (resolve1),
    .slots    (slots)
  );

  return_stack #(
    .ras_depth (ras_depth)
  ) ras0 (
    .clk      (clk),
    .reset    (reset),
    .resolve0 (resolve0),
    .resolve1 (resolve1),
    .pop      (pop),
    .issue    (issue),
    .top      (ras_top)
  );

  slot_select select0 (
    .pc      (pc),
    .slots   (slots),
    .ras_top (ras_top),
    .pred    (pred),
    .pop     (pop)
  );

endmodule

//--- logic/fetch_pc_gen.sv
// consumer must never return more credits than it holds; a redirect blocks issue that cycle
module fetch_pc_gen #(
  parameter int unsigned credits  = 4,
  parameter logic [31:0] reset_pc = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  credit_return,
  input  bpu_pkg::resolve_t     resolve0,
  input  bpu_pkg::resolve_t     resolve1,
  input  bpu_pkg::fetch_group_t pred,
  output logic [31:0]           pc,
  output logic                  issue,
  output bpu_pkg::fetch_group_t group
);

  localparam int unsigned cnt_w = $clog2(credits + 1);

  logic [cnt_w-1:0]      credit_q;
  logic                  redirect0;
  logic                  redirect;
  logic                  group_valid_q;
  bpu_pkg::fetch_group_t group_q;

  assign redirect0 = resolve0.valid && resolve0.mispredict;
  assign redirect  = redirect0 || (resolve1.valid && resolve1.mispredict);
  assign issue     = (credit_q != '0) && !redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_q <= cnt_w'(credits);
    end else if (issue && !credit_return) begin
      credit_q <= credit_q - cnt_w'(1);
    end else if (credit_return && !issue) begin
      credit_q <= credit_q + cnt_w'(1);
    end
  end

  // port 0 redirect has priority
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect0 ? resolve0.redirect_pc : resolve1.redirect_pc;
    end else if (issue) begin
      pc <= pred.next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      group_valid_q <= 1'b0;
    end else begin
      group_valid_q <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      group_q <= pred;
    end
  end

  always_comb begin
    group       = group_q;
    group.valid = group_valid_q;
  end

endmodule

//--- verification/fetch_frontend_tb.sv
// step-table testbench for default parameters only; the model assumes table_entries and ras_depth below
module fetch_frontend_tb;

  localparam int unsigned table_entries = 64;
  localparam int unsigned ras_depth     = 8;
  localparam int unsigned credits       = 4;
  localparam logic [31:0] reset_pc      = 32'h0000_1000;
  localparam int unsigned idx_w         = $clog2(table_entries);

  // one table row, inputs for a cycle plus the issue it should cause
  typedef struct packed {
    bpu_pkg::resolve_t r0;
    bpu_pkg::resolve_t r1;
    logic              cr;
    logic              exp_issue;
  } step_t;

  logic                  clk;
  logic                  reset;
  logic                  credit_return;
  bpu_pkg::resolve_t     resolve0;
  bpu_pkg::resolve_t     resolve1;
  bpu_pkg::fetch_group_t group;

  step_t       rows[$];
  int          build_credits;
  int          lfsr_start;
  int          cycles = 0;
  int          limit = 0;
  logic [31:0] lfsr;

  // reference copy of pc, tables and stack
  logic                  m_valid [table_entries];
  logic [31:0]           m_tag [table_entries];
  bpu_pkg::branch_kind_e m_kind [table_entries];
  logic [31:0]           m_target [table_entries];
  int                    m_ctr [table_entries];
  logic [31:0]           m_stack [ras_depth];
  int                    m_sp;
  logic [31:0]           m_pc;

  fetch_frontend #(
    .table_entries (table_entries),
    .ras_depth     (ras_depth),
    .credits       (credits),
    .reset_pc      (reset_pc)
  ) dut0 (
    .clk           (clk),
    .reset         (reset),
    .credit_return (credit_return),
    .resolve0      (resolve0),
    .resolve1      (resolve1),
    .group         (group)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: the step table did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic bpu_pkg::resolve_t make_resolve(input logic [31:0] pc, input logic br,
      input logic taken, input bpu_pkg::branch_kind_e kind, input logic [31:0] target,
      input logic misp, input logic [31:0] rpc);
    bpu_pkg::resolve_t r;
    r.valid       = 1'b1;
    r.pc          = pc;
    r.is_branch   = br;
    r.taken       = taken;
    r.mispredict  = misp;
    r.target      = target;
    r.kind        = kind;
    r.redirect_pc = rpc;
    return r;
  endfunction

  function automatic bpu_pkg::resolve_t redirect_only(input logic [31:0] rpc);
    return make_resolve(32'h0, 1'b0, 1'b0, bpu_pkg::br_cond, 32'h0, 1'b1, rpc);
  endfunction

  task automatic add_step(input bpu_pkg::resolve_t r0, input bpu_pkg::resolve_t r1,
      input logic cr);
    step_t s;
    logic  redirect;
    redirect    = (r0.valid && r0.mispredict) || (r1.valid && r1.mispredict);
    s.r0        = r0;
    s.r1        = r1;
    // consumer can only hand back buffers it holds
    s.cr        = cr && (build_credits < credits);
    s.exp_issue = (build_credits != 0) && !redirect;
    build_credits = build_credits + int'(s.cr) - int'(s.exp_issue);
    rows.push_back(s);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic predict(input logic [31:0] pc, output bpu_pkg::fetch_group_t g,
      output logic pop);
    logic [31:0] base;
    logic [31:0] a;
    int          idx;
    int          first;
    int          first_idx;
    base      = {pc[31:4], 4'h0};
    g         = '0;
    g.pc      = pc;
    g.next_pc = base + 32'd16;
    pop       = 1'b0;
    first     = -1;
    first_idx = 0;
    for (int k = int'(pc[3:2]); k < bpu_pkg::group_slots; k++) begin
      if (first < 0) begin
        a   = base + 32'(4 * k);
        idx = (a >> 2) % table_entries;
        g.slot_valid[k] = 1'b1;
        if (m_valid[idx] && m_tag[idx] == (a >> (idx_w + 2)) && m_ctr[idx] >= 2) begin
          first     = k;
          first_idx = idx;
        end
      end
    end
    if (first >= 0) begin
      g.taken_slot[first] = 1'b1;
      pop = (m_kind[first_idx] == bpu_pkg::br_ret);
      if (pop) begin
        g.next_pc = m_stack[(m_sp + ras_depth - 1) % ras_depth];
      end else begin
        g.next_pc = m_target[first_idx];
      end
    end
  endtask

  task automatic train(input bpu_pkg::resolve_t r);
    int   idx;
    logic hit;
    if (r.valid && r.is_branch) begin
      idx = (r.pc >> 2) % table_entries;
      hit = m_valid[idx] && (m_tag[idx] == (r.pc >> (idx_w + 2)));
      if (r.taken) begin
        m_ctr[idx]    = !hit ? 2 : ((m_ctr[idx] == 3) ? 3 : m_ctr[idx] + 1);
        m_valid[idx]  = 1'b1;
        m_tag[idx]    = r.pc >> (idx_w + 2);
        m_kind[idx]   = r.kind;
        m_target[idx] = r.target;
        if (r.kind == bpu_pkg::br_call) begin
          m_stack[m_sp] = r.pc + 32'd4;
          m_sp = (m_sp + 1) % ras_depth;
        end
      end else if (hit && m_ctr[idx] > 0) begin
        m_ctr[idx] = m_ctr[idx] - 1;
      end
    end
  endtask

  initial begin
    bpu_pkg::fetch_group_t exp_group;
    bpu_pkg::resolve_t     idle;
    logic                  exp_pop;
    int                    returned;
    int                    lfsr_issues;
    idle          = '0;
    returned      = 0;
    lfsr_issues   = 0;
    build_credits = credits;
    lfsr          = 32'h33bd85d7;
    for (int e = 0; e < table_entries; e++) begin
      m_valid[e] = 1'b0;
      m_ctr[e]   = 0;
    end
    m_sp = 0;
    m_pc = reset_pc;

    // sequential run, then an unaligned redirect
    for (int k = 0; k < 4; k++) add_step(idle, idle, 1'b1);
    add_step(redirect_only(32'h0000_2008), idle, 1'b1);
    add_step(idle, idle, 1'b1);
    add_step(idle, idle, 1'b1);
    // jump allocation at slot 1 of 0x3000
    add_step(make_resolve(32'h0000_3004, 1'b1, 1'b1, bpu_pkg::br_jump, 32'h0000_5000,
                          1'b1, 32'h0000_3000), idle, 1'b1);
    add_step(idle, idle, 1'b1);
    add_step(idle, idle, 1'b1);
    // hysteresis on the same entry
    add_step(make_resolve(32'h0000_3004, 1'b1, 1'b0, bpu_pkg::br_cond, 32'h0000_6000,
                          1'b1, 32'h0000_3000), idle, 1'b1);
    add_step(idle, idle, 1'b1);
    add_step(make_resolve(32'h0000_3004, 1'b1, 1'b1, bpu_pkg::br_cond, 32'h0000_6000,
                          1'b1, 32'h0000_3000),
             make_resolve(32'h0000_3004, 1'b1, 1'b1, bpu_pkg::br_cond, 32'h0000_6000,
                          1'b0, 32'h0), 1'b1);
    // third taken resolve against the saturated counter
    add_step(make_resolve(32'h0000_3004, 1'b1, 1'b1, bpu_pkg::br_cond, 32'h0000_6000,
                          1'b0, 32'h0), idle, 1'b1);
    add_step(make_resolve(32'h0000_3004, 1'b1, 1'b0, bpu_pkg::br_cond, 32'h0000_6000,
                          1'b1, 32'h0000_3000), idle, 1'b1);
    add_step(idle, idle, 1'b1);
    add_step(idle, idle, 1'b1);
    // call pushes, trained return pops
    add_step(make_resolve(32'h0000_4008, 1'b1, 1'b1, bpu_pkg::br_call, 32'h0000_7000,
                          1'b0, 32'h0),
             make_resolve(32'h0000_7014, 1'b1, 1'b1, bpu_pkg::br_ret, 32'h0,
                          1'b1, 32'h0000_7010), 1'b1);
    add_step(idle, idle, 1'b1);
    add_step(idle, idle, 1'b1);
    // two calls in one cycle
    add_step(make_resolve(32'h0000_4100, 1'b1, 1'b1, bpu_pkg::br_call, 32'h0000_7100,
                          1'b1, 32'h0000_7010),
             make_resolve(32'h0000_4200, 1'b1, 1'b1, bpu_pkg::br_call, 32'h0000_7200,
                          1'b0, 32'h0), 1'b1);
    add_step(idle, idle, 1'b1);
    add_step(redirect_only(32'h0000_7010), idle, 1'b1);
    add_step(idle, idle, 1'b1);
    // mispredict on both ports, port 0 wins
    add_step(redirect_only(32'h0000_8000), redirect_only(32'h0000_9000), 1'b1);
    add_step(idle, idle, 1'b1);
    // refill credits, then exhaust them
    for (int k = 0; k < 4; k++) add_step(redirect_only(32'h0000_a000), idle, 1'b1);
    for (int k = 0; k < 8; k++) add_step(idle, idle, 1'b0);
    lfsr_start = rows.size();
    for (int k = 0; k < 24; k++) begin
      lfsr = lfsr_next(lfsr);
      add_step(idle, idle, lfsr[0]);
    end
    for (int k = 0; k < 6; k++) add_step(idle, idle, 1'b0);
    limit = 2 * rows.size() + 40;

    credit_return = 1'b0;
    resolve0      = '0;
    resolve1      = '0;
    reset         = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      resolve0      = rows[i].r0;
      resolve1      = rows[i].r1;
      credit_return = rows[i].cr;
      predict(m_pc, exp_group, exp_pop);
      // advance the model past the coming rising edge
      if (rows[i].r0.valid && rows[i].r0.mispredict) begin
        m_pc = rows[i].r0.redirect_pc;
      end else if (rows[i].r1.valid && rows[i].r1.mispredict) begin
        m_pc = rows[i].r1.redirect_pc;
      end else if (rows[i].exp_issue) begin
        m_pc = exp_group.next_pc;
      end
      if (rows[i].exp_issue && exp_pop) begin
        m_sp = (m_sp + ras_depth - 1) % ras_depth;
      end
      train(rows[i].r0);
      train(rows[i].r1);
      @(negedge clk);
      compare("group.valid", 32'(group.valid), 32'(rows[i].exp_issue));
      if (rows[i].exp_issue) begin
        compare("group.pc", group.pc, exp_group.pc);
        compare("group.slot_valid", 32'(group.slot_valid), 32'(exp_group.slot_valid));
        compare("group.taken_slot", 32'(group.taken_slot), 32'(exp_group.taken_slot));
        compare("group.next_pc", group.next_pc, exp_group.next_pc);
      end
      if (i >= lfsr_start) begin
        lfsr_issues = lfsr_issues + int'(group.valid);
        returned    = returned + int'(rows[i].cr);
      end
    end
    resolve0      = '0;
    resolve1      = '0;
    credit_return = 1'b0;
    compare("issues after credit returns", lfsr_issues, returned);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
